// File: compile.f
hdl/load_pkg.sv
hdl/load_decode.sv
hdl/axi_read_master.sv
hdl/load_result.sv
hdl/axi_load_top.sv
verification/axi_load_props.sv
verification/axi_load_tb.sv

// File: hdl/axi_load_top.sv
`timescale 1ns/10ps

module axi_load_top (
	input  logic                         clk,
	input  logic                         reset_n,
	// CPU request / response
	input  logic                         req_valid_i,
	output logic                         req_ready_o,
	input  load_pkg::load_req_t          req_i,
	output logic                         rsp_valid_o,
	input  logic                         rsp_ready_i,
	output load_pkg::load_rsp_t          rsp_o,
	// AXI4 read address channel
	output logic                         axi_ar_valid_o,
	input  logic                         axi_ar_ready_i,
	output logic [load_pkg::tag_w-1:0]   axi_ar_id_o,
	output logic [load_pkg::addr_w-1:0]  axi_ar_addr_o,
	output logic [7:0]                   axi_ar_len_o,
	output logic [2:0]                   axi_ar_size_o,
	output logic [1:0]                   axi_ar_burst_o,
	// AXI4 read data channel
	input  logic                         axi_r_valid_i,
	output logic                         axi_r_ready_o,
	input  logic [load_pkg::data_w-1:0]  axi_r_data_i,
	input  logic [1:0]                   axi_r_resp_i,
	input  logic [load_pkg::tag_w-1:0]   axi_r_id_i,
	input  logic                         axi_r_last_i
);
	import load_pkg::*;

	logic     cmd_valid;
	logic     cmd_ready;
	rd_cmd_t  cmd;
	logic     beat_valid;
	logic     beat_ready;
	rd_beat_t beat;

	load_decode u_decode (
		.clk         (clk),
		.reset_n     (reset_n),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_i       (req_i),
		.cmd_valid_o (cmd_valid),
		.cmd_ready_i (cmd_ready),
		.cmd_o       (cmd)
	);

	axi_read_master u_master (
		.clk            (clk),
		.reset_n        (reset_n),
		.cmd_valid_i    (cmd_valid),
		.cmd_ready_o    (cmd_ready),
		.cmd_i          (cmd),
		.beat_valid_o   (beat_valid),
		.beat_ready_i   (beat_ready),
		.beat_o         (beat),
		.axi_ar_valid_o (axi_ar_valid_o),
		.axi_ar_ready_i (axi_ar_ready_i),
		.axi_ar_id_o    (axi_ar_id_o),
		.axi_ar_addr_o  (axi_ar_addr_o),
		.axi_ar_len_o   (axi_ar_len_o),
		.axi_ar_size_o  (axi_ar_size_o),
		.axi_ar_burst_o (axi_ar_burst_o),
		.axi_r_valid_i  (axi_r_valid_i),
		.axi_r_ready_o  (axi_r_ready_o),
		.axi_r_data_i   (axi_r_data_i),
		.axi_r_resp_i   (axi_r_resp_i),
		.axi_r_id_i     (axi_r_id_i),
		.axi_r_last_i   (axi_r_last_i)
	);

	load_result u_result (
		.clk          (clk),
		.reset_n      (reset_n),
		.beat_valid_i (beat_valid),
		.beat_ready_o (beat_ready),
		.beat_i       (beat),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_ready_i  (rsp_ready_i),
		.rsp_o        (rsp_o)
	);

endmodule

// File: hdl/axi_read_master.sv
`timescale 1ns/10ps

module axi_read_master (
	input  logic                         clk,
	input  logic                         reset_n,
	input  logic                         cmd_valid_i,
	output logic                         cmd_ready_o,
	input  load_pkg::rd_cmd_t            cmd_i,
	output logic                         beat_valid_o,
	input  logic                         beat_ready_i,
	output load_pkg::rd_beat_t           beat_o,
	output logic                         axi_ar_valid_o,
	input  logic                         axi_ar_ready_i,
	output logic [load_pkg::tag_w-1:0]   axi_ar_id_o,
	output logic [load_pkg::addr_w-1:0]  axi_ar_addr_o,
	output logic [7:0]                   axi_ar_len_o,
	output logic [2:0]                   axi_ar_size_o,
	output logic [1:0]                   axi_ar_burst_o,
	input  logic                         axi_r_valid_i,
	output logic                         axi_r_ready_o,
	input  logic [load_pkg::data_w-1:0]  axi_r_data_i,
	input  logic [1:0]                   axi_r_resp_i,
	input  logic [load_pkg::tag_w-1:0]   axi_r_id_i,
	input  logic                         axi_r_last_i
);
	import load_pkg::*;

	typedef enum logic [1:0] {
		rd_idle,
		rd_addr,
		rd_data
	} rd_state_e;

	rd_state_e state_q;
	rd_cmd_t   cmd_q;
	rd_beat_t  beat_q;
	logic      beat_valid_q;
	logic      cmd_take;
	logic      skip_bus;
	logic      ar_fire;
	logic      r_fire;
	logic      r_bad;

	// only take a command when idle and the beat slot frees up
	assign cmd_ready_o = (state_q == rd_idle) && (!beat_valid_q || beat_ready_i);
	assign cmd_take    = cmd_valid_i && cmd_ready_o;
	assign skip_bus    = cmd_take && cmd_i.misaligned;

	assign ar_fire = axi_ar_valid_o && axi_ar_ready_i;
	assign r_fire  = axi_r_valid_i && axi_r_ready_o;
	assign r_bad   = (axi_r_id_i != cmd_q.tag) || !axi_r_last_i;	// wrong id or not last

	// AR fields come straight from the held command so they stay stable
	assign axi_ar_valid_o = (state_q == rd_addr);
	assign axi_ar_id_o    = cmd_q.tag;
	assign axi_ar_addr_o  = cmd_q.addr;
	assign axi_ar_len_o   = 8'd0;	// single beat
	assign axi_ar_size_o  = cmd_q.size;
	assign axi_ar_burst_o = axi_burst_incr;
	assign axi_r_ready_o  = (state_q == rd_data);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q <= rd_idle;
		end else begin
			case (state_q)
				rd_idle: if (cmd_take && !cmd_i.misaligned) state_q <= rd_addr;
				rd_addr: if (ar_fire) state_q <= rd_data;
				rd_data: if (r_fire) state_q <= rd_idle;
				default: state_q <= rd_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			beat_valid_q <= 1'b0;
		end else if (r_fire || skip_bus) begin
			beat_valid_q <= 1'b1;
		end else if (beat_ready_i) begin
			beat_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_take) begin
			cmd_q <= cmd_i;
		end
		if (skip_bus) begin
			// bus-free beat, result stage reports the misalignment
			beat_q.data       <= '0;
			beat_q.resp       <= axi_resp_okay;
			beat_q.lane       <= cmd_i.lane;
			beat_q.size       <= cmd_i.size;
			beat_q.sign       <= cmd_i.sign;
			beat_q.tag        <= cmd_i.tag;
			beat_q.misaligned <= 1'b1;
		end else if (r_fire) begin
			beat_q.data       <= axi_r_data_i;
			beat_q.resp       <= r_bad ? axi_resp_slverr : axi_r_resp_i;
			beat_q.lane       <= cmd_q.lane;
			beat_q.size       <= cmd_q.size;
			beat_q.sign       <= cmd_q.sign;
			beat_q.tag        <= cmd_q.tag;
			beat_q.misaligned <= 1'b0;
		end
	end

	assign beat_valid_o = beat_valid_q;
	assign beat_o       = beat_q;

endmodule

// File: hdl/load_decode.sv
`timescale 1ns/10ps

module load_decode (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                req_valid_i,
	output logic                req_ready_o,
	input  load_pkg::load_req_t req_i,
	output logic                cmd_valid_o,
	input  logic                cmd_ready_i,
	output load_pkg::rd_cmd_t   cmd_o
);
	import load_pkg::*;

	rd_cmd_t cmd_d;
	rd_cmd_t cmd_q;
	logic    valid_q;
	logic    req_take;

	// one entry, refilled in the same cycle it drains
	assign req_ready_o = !valid_q || cmd_ready_i;
	assign req_take    = req_valid_i && req_ready_o;

	always_comb begin
		cmd_d.addr = {req_i.addr[addr_w-1:3], 3'b000};
		cmd_d.lane = req_i.addr[2:0];
		cmd_d.tag  = req_i.tag;
		cmd_d.sign = (req_i.op == lb) || (req_i.op == lh) || (req_i.op == lw);

		case (req_i.op)
			lb, lbu: cmd_d.size = 3'd0;
			lh, lhu: cmd_d.size = 3'd1;
			lw, lwu: cmd_d.size = 3'd2;
			default: cmd_d.size = 3'd3;	// ld and the spare code
		endcase

		// low address bits below the access size must be zero
		case (cmd_d.size)
			3'd0:    cmd_d.misaligned = 1'b0;
			3'd1:    cmd_d.misaligned = req_i.addr[0];
			3'd2:    cmd_d.misaligned = |req_i.addr[1:0];
			default: cmd_d.misaligned = |req_i.addr[2:0];
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid_q <= 1'b0;
		end else if (req_take) begin
			valid_q <= 1'b1;
		end else if (cmd_ready_i) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (req_take) begin
			cmd_q <= cmd_d;
		end
	end

	assign cmd_valid_o = valid_q;
	assign cmd_o       = cmd_q;

endmodule

// File: hdl/load_pkg.sv
package load_pkg;

	localparam int addr_w = 32;
	localparam int data_w = 64;
	localparam int tag_w  = 4;	// also the AXI ID width

	typedef enum logic [2:0] {
		lb  = 3'd0,
		lh  = 3'd1,
		lw  = 3'd2,
		ld  = 3'd3,
		lbu = 3'd4,
		lhu = 3'd5,
		lwu = 3'd6
	} load_op_e;

	typedef enum logic [1:0] {
		st_ok         = 2'd0,
		st_bus_err    = 2'd1,	// SLVERR or DECERR from the slave
		st_misaligned = 2'd2	// no bus access made
	} load_status_e;

	// AXI encodings
	localparam logic [1:0] axi_burst_incr  = 2'b01;
	localparam logic [1:0] axi_resp_okay   = 2'b00;
	localparam logic [1:0] axi_resp_slverr = 2'b10;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		load_op_e          op;
		logic [tag_w-1:0]  tag;
	} load_req_t;

	// decode -> execute
	typedef struct packed {
		logic [addr_w-1:0] addr;	// 8-byte aligned
		logic [2:0]        size;	// log2 of bytes
		logic [2:0]        lane;	// byte offset in the beat
		logic              sign;
		logic [tag_w-1:0]  tag;
		logic              misaligned;
	} rd_cmd_t;

	// execute -> result
	typedef struct packed {
		logic [data_w-1:0] data;
		logic [1:0]        resp;
		logic [2:0]        lane;
		logic [2:0]        size;
		logic              sign;
		logic [tag_w-1:0]  tag;
		logic              misaligned;
	} rd_beat_t;

	typedef struct packed {
		logic [data_w-1:0] data;
		logic [tag_w-1:0]  tag;
		load_status_e      status;
	} load_rsp_t;

endpackage

// File: hdl/load_result.sv
`timescale 1ns/10ps

module load_result (
	input  logic                clk,
	input  logic                reset_n,
	input  logic                beat_valid_i,
	output logic                beat_ready_o,
	input  load_pkg::rd_beat_t  beat_i,
	output logic                rsp_valid_o,
	input  logic                rsp_ready_i,
	output load_pkg::load_rsp_t rsp_o
);
	import load_pkg::*;

	load_rsp_t         rsp_q;
	logic              rsp_valid_q;
	logic              beat_take;
	logic [data_w-1:0] shifted;
	logic [data_w-1:0] ext;
	load_status_e      status;

	assign beat_ready_o = !rsp_valid_q || rsp_ready_i;
	assign beat_take    = beat_valid_i && beat_ready_o;

	// bring the addressed lane down to bit 0
	assign shifted = beat_i.data >> {beat_i.lane, 3'b000};

	// mask to the access size, fill from the top byte when signed
	always_comb begin
		case (beat_i.size)
			3'd0:    ext = {{(data_w-8){beat_i.sign && shifted[7]}}, shifted[7:0]};
			3'd1:    ext = {{(data_w-16){beat_i.sign && shifted[15]}}, shifted[15:0]};
			3'd2:    ext = {{(data_w-32){beat_i.sign && shifted[31]}}, shifted[31:0]};
			default: ext = shifted;
		endcase
	end

	always_comb begin
		if (beat_i.misaligned) begin
			status = st_misaligned;	// wins over any resp
		end else if (beat_i.resp != axi_resp_okay) begin
			status = st_bus_err;
		end else begin
			status = st_ok;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rsp_valid_q <= 1'b0;
		end else if (beat_take) begin
			rsp_valid_q <= 1'b1;
		end else if (rsp_ready_i) begin
			rsp_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (beat_take) begin
			rsp_q.data   <= (status == st_ok) ? ext : '0;
			rsp_q.tag    <= beat_i.tag;
			rsp_q.status <= status;
		end
	end

	assign rsp_valid_o = rsp_valid_q;
	assign rsp_o       = rsp_q;

endmodule

// File: run.sh
#!/bin/sh
# build and run the load path testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/10ps --top-module axi_load_tb \
	-f compile.f -o axi_load_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/axi_load_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: verification/axi_load_props.sv
`timescale 1ns/10ps

module axi_load_props (
	input logic                        clk,
	input logic                        reset_n,
	input logic                        axi_ar_valid_o,
	input logic                        axi_ar_ready_i,
	input logic [load_pkg::addr_w-1:0] axi_ar_addr_o,
	input logic [load_pkg::tag_w-1:0]  axi_ar_id_o,
	input logic                        rsp_valid_o,
	input logic                        rsp_ready_i,
	input load_pkg::load_rsp_t         rsp_o
);

	// AR held with the same fields until the slave takes it
	ar_hold: assert property (@(posedge clk) disable iff (!reset_n)
		axi_ar_valid_o && !axi_ar_ready_i |=>
			axi_ar_valid_o && $stable(axi_ar_addr_o) && $stable(axi_ar_id_o))
		else $error("arvalid dropped or AR fields changed before arready");

	rsp_hold: assert property (@(posedge clk) disable iff (!reset_n)
		rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
		else $error("response dropped or changed before rsp_ready_i");

	reset_idle: assert property (@(posedge clk)
		!reset_n |=> !axi_ar_valid_o && !rsp_valid_o)	// one reset edge is enough
		else $error("arvalid or rsp_valid_o high after a reset cycle");

endmodule

bind axi_load_top axi_load_props props0 (
	.clk            (clk),
	.reset_n        (reset_n),
	.axi_ar_valid_o (axi_ar_valid_o),
	.axi_ar_ready_i (axi_ar_ready_i),
	.axi_ar_addr_o  (axi_ar_addr_o),
	.axi_ar_id_o    (axi_ar_id_o),
	.rsp_valid_o    (rsp_valid_o),
	.rsp_ready_i    (rsp_ready_i),
	.rsp_o          (rsp_o)
);

// File: verification/axi_load_tb.sv
`timescale 1ns/10ps

module axi_load_tb;
	import load_pkg::*;

	localparam int step_limit = 200;	// cycles any single wait may take

	// expected AR fields queued per aligned request
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [tag_w-1:0]  id;
		logic [2:0]        size;
	} ar_exp_t;

	logic              clk;
	logic              reset_n;
	logic              req_valid_i;
	logic              req_ready_o;
	load_req_t         req_i;
	logic              rsp_valid_o;
	logic              rsp_ready_i;
	load_rsp_t         rsp_o;
	logic              axi_ar_valid_o;
	logic              axi_ar_ready_i;
	logic [tag_w-1:0]  axi_ar_id_o;
	logic [addr_w-1:0] axi_ar_addr_o;
	logic [7:0]        axi_ar_len_o;
	logic [2:0]        axi_ar_size_o;
	logic [1:0]        axi_ar_burst_o;
	logic              axi_r_valid_i;
	logic              axi_r_ready_o;
	logic [data_w-1:0] axi_r_data_i;
	logic [1:0]        axi_r_resp_i;
	logic [tag_w-1:0]  axi_r_id_i;
	logic              axi_r_last_i;

	load_rsp_t  exp_q[$];	// expected responses in request order
	ar_exp_t    ar_q[$];
	string      test_name = "none";
	logic [3:0] next_tag = '0;
	int         aligned_cnt = 0;
	int         ar_cnt = 0;

	axi_load_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("test %s: %s", test_name, msg);
		$display("*** FAILED ***");
		$fatal(1, "run aborted");
	endtask

	task automatic value_mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
		$display("error: test %s, %s expected %0h actual %0h", test_name, what, exp, act);
		$display("*** FAILED ***");
		$fatal(1, "value check failed");
	endtask

	function automatic logic [7:0] mem_byte(input logic [31:0] a);
		logic [31:0] v;
		v = a * 32'd13 + 32'd5;
		return v[7:0] ^ v[31:24];	// top byte folded in so high bits count too
	endfunction

	function automatic logic [2:0] size_log2(input load_op_e op);
		case (op)
			lb, lbu: return 3'd0;
			lh, lhu: return 3'd1;
			lw, lwu: return 3'd2;
			default: return 3'd3;
		endcase
	endfunction

	// reference load built from the memory model bytes and then extended
	function automatic load_rsp_t model_load(input load_req_t r);
		load_rsp_t   m;
		logic [63:0] v;
		int          n;
		logic        neg;
		n = 1 << size_log2(r.op);
		m.tag    = r.tag;
		m.data   = '0;
		m.status = st_ok;
		if (r.addr % n != 0) begin
			m.status = st_misaligned;
		end else if (r.addr[31:28] == 4'hf) begin
			m.status = st_bus_err;	// slave answers SLVERR up there
		end else begin
			v = '0;
			for (int i = 0; i < n; i++) begin
				v[8*i +: 8] = mem_byte(r.addr + i);
			end
			neg = v[8*n-1] && (r.op == lb || r.op == lh || r.op == lw);
			for (int i = n; i < 8; i++) begin
				v[8*i +: 8] = {8{neg}};
			end
			m.data = v;
		end
		return m;
	endfunction

	// called 1 ns after an edge and returns 1 ns after the accepting edge
	task automatic send_req(input logic [31:0] addr, input load_op_e op);
		load_req_t r;
		load_rsp_t m;
		ar_exp_t   a;
		int        waited;
		r.addr = addr;
		r.op   = op;
		r.tag  = next_tag;
		m      = model_load(r);
		a.addr = addr & ~32'h7;	// AR address has the low three bits cleared
		a.id   = next_tag;
		a.size = size_log2(op);
		req_i       = r;
		req_valid_i = 1'b1;
		waited      = 0;
		@(posedge clk);
		while (!req_ready_o) begin
			waited++;
			assert (waited < step_limit) else abort_run("request was never accepted");
			@(posedge clk);
		end
		exp_q.push_back(m);
		if (m.status != st_misaligned) begin
			ar_q.push_back(a);
			aligned_cnt++;
		end
		next_tag++;
		#1;
		req_valid_i = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		@(posedge clk);
		while (exp_q.size() != 0) begin
			waited++;
			assert (waited < step_limit) else abort_run("responses still outstanding");
			@(posedge clk);
		end
		#1;
	endtask

	// AXI slave serving one read at a time with 0-3 cycle delays on arready and rvalid
	initial begin : axi_slave
		ar_exp_t          e;
		int               ar_wait;
		int               r_wait;
		logic             r_pend;
		logic [31:0]      r_addr;
		logic [tag_w-1:0] r_id;
		axi_ar_ready_i = 1'b0;
		axi_r_valid_i  = 1'b0;
		axi_r_data_i   = '0;
		axi_r_resp_i   = axi_resp_okay;
		axi_r_id_i     = '0;
		axi_r_last_i   = 1'b0;
		ar_wait        = -1;
		r_wait         = 0;
		r_pend         = 1'b0;
		r_addr         = '0;
		r_id           = '0;
		forever begin
			@(posedge clk);
			if (axi_ar_valid_o && axi_ar_ready_i) begin
				ar_cnt++;
				assert (ar_q.size() > 0) else abort_run("AR handshake without a pending load");
				e = ar_q.pop_front();
				assert (axi_ar_addr_o == e.addr)
					else value_mismatch("araddr", 64'(e.addr), 64'(axi_ar_addr_o));
				assert (axi_ar_len_o == 8'd0)
					else value_mismatch("arlen", 64'd0, 64'(axi_ar_len_o));
				assert (axi_ar_burst_o == axi_burst_incr)
					else value_mismatch("arburst", 64'(axi_burst_incr), 64'(axi_ar_burst_o));
				assert (axi_ar_id_o == e.id)
					else value_mismatch("arid", 64'(e.id), 64'(axi_ar_id_o));
				assert (axi_ar_size_o == e.size)
					else value_mismatch("arsize", 64'(e.size), 64'(axi_ar_size_o));
				r_addr  = axi_ar_addr_o;
				r_id    = axi_ar_id_o;
				r_wait  = $urandom_range(3, 0);
				r_pend  = 1'b1;
				ar_wait = -1;
			end
			if (axi_r_valid_i && axi_r_ready_o) begin
				r_pend = 1'b0;
			end
			#1;
			axi_ar_ready_i = 1'b0;
			if (axi_ar_valid_o && !r_pend) begin
				if (ar_wait < 0) begin
					ar_wait = $urandom_range(3, 0);
				end
				if (ar_wait == 0) begin
					axi_ar_ready_i = 1'b1;
				end else begin
					ar_wait--;
				end
			end
			axi_r_valid_i = 1'b0;
			if (r_pend && r_wait == 0) begin
				axi_r_valid_i = 1'b1;	// held until rready
				axi_r_last_i  = 1'b1;
				axi_r_id_i    = r_id;
				axi_r_resp_i  = (r_addr[31:28] == 4'hf) ? 2'b10 : axi_resp_okay;
				for (int i = 0; i < 8; i++) begin
					axi_r_data_i[8*i +: 8] = mem_byte(r_addr + i);
				end
			end else if (r_pend) begin
				r_wait--;
			end
		end
	end

	// random rsp_ready_i and in-order compare of responses
	initial begin : rsp_side
		load_rsp_t e;
		rsp_ready_i = 1'b0;
		forever begin
			@(posedge clk);
			if (reset_n && rsp_valid_o && rsp_ready_i) begin
				assert (exp_q.size() > 0)
					else abort_run("response arrived with nothing outstanding");
				e = exp_q.pop_front();
				assert (rsp_o.tag == e.tag)
					else value_mismatch("tag", 64'(e.tag), 64'(rsp_o.tag));
				assert (rsp_o.status == e.status)
					else value_mismatch("status", 64'(e.status), 64'(rsp_o.status));
				assert (rsp_o.data == e.data) else value_mismatch("data", e.data, rsp_o.data);
			end
			#1;
			rsp_ready_i = ($urandom_range(99, 0) < 70);	// about 70% ready
		end
	end

	initial begin : main
		load_op_e    wide_ops[5];
		logic [31:0] addr;
		load_op_e    op;
		int          gap;
		void'($urandom(22));
		wide_ops    = '{lh, lw, ld, lhu, lwu};
		reset_n     = 1'b0;
		req_valid_i = 1'b0;
		req_i       = '0;
		repeat (2) @(posedge clk);
		#1;
		reset_n   = 1'b1;
		test_name = "reset";
		@(posedge clk);
		assert (req_ready_o == 1'b1) else value_mismatch("req_ready_o", 64'd1, 64'(req_ready_o));
		assert (rsp_valid_o == 1'b0) else value_mismatch("rsp_valid_o", 64'd0, 64'(rsp_valid_o));
		assert (axi_ar_valid_o == 1'b0)
			else value_mismatch("axi_ar_valid_o", 64'd0, 64'(axi_ar_valid_o));
		assert (axi_r_ready_o == 1'b0)
			else value_mismatch("axi_r_ready_o", 64'd0, 64'(axi_r_ready_o));
		#1;

		test_name = "extension";
		for (int k = 0; k < 28; k++) begin
			op   = load_op_e'(3'(k % 7));
			addr = $urandom();
			addr[31] = 1'b0;	// stay clear of the error region
			addr = addr & ~((32'd1 << size_log2(op)) - 32'd1);
			send_req(addr, op);
		end
		wait_drain();

		test_name = "misaligned";
		for (int k = 0; k < 20; k++) begin
			addr    = $urandom();
			addr[0] = 1'b1;
			send_req(addr, wide_ops[k % 5]);
		end
		wait_drain();

		test_name = "bus_error";
		for (int k = 0; k < 14; k++) begin
			op   = load_op_e'(3'(k % 7));
			addr = $urandom();
			addr[31:28] = 4'hf;
			addr = addr & ~((32'd1 << size_log2(op)) - 32'd1);
			send_req(addr, op);
		end
		wait_drain();

		test_name = "random";
		for (int k = 0; k < 300; k++) begin
			send_req($urandom(), load_op_e'(3'($urandom_range(6, 0))));
			gap = $urandom_range(2, 0);
			if (gap > 0) begin
				repeat (gap) @(posedge clk);
				#1;
			end
		end
		wait_drain();

		test_name = "totals";
		assert (ar_cnt == aligned_cnt)
			else value_mismatch("AR handshakes", 64'(aligned_cnt), 64'(ar_cnt));
		// every request answered, so nothing more may be offered
		assert (rsp_valid_o == 1'b0)
			else value_mismatch("rsp_valid_o after drain", 64'd0, 64'(rsp_valid_o));
		$display("*** PASSED ***");
		$finish;
	end

endmodule
